// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

  localparam int XLEN       = 32;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  localparam logic [XLEN-1:0] RESET_PC  = '0;
  localparam logic [ILEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

  // funct3 of OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_ARITHI = 7'b0010011,
    OP_ARITHR = 7'b0110011,
    OP_FENCE  = 7'b0001111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALUOP_ADD, ALUOP_SUB, ALUOP_SLL, ALUOP_SLT, ALUOP_SLTU, ALUOP_XOR,
    ALUOP_SRL, ALUOP_SRA, ALUOP_OR, ALUOP_AND, ALUOP_LINK
  } aluop_e;

  typedef enum logic [1:0] {SRC1_REG, SRC1_PC, SRC1_ZERO} alu_src1_e;
  typedef enum logic [1:0] {SRC2_REG, SRC2_IMM} alu_src2_e;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_f3_e;

  typedef struct packed {
    logic            valid;
    aluop_e          aluop;
    alu_src1_e       src1;
    alu_src2_e       src2;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    reg_addr_t       rd;
    logic            wreg;
    logic            memrd;
    logic            memwr;
  } id_ex_t;

  // What a later stage offers for forwarding
  typedef struct packed {
    logic            wreg;
    reg_addr_t       rd;
    logic            memrd;
    logic [XLEN-1:0] data;
  } fwd_t;

  typedef struct packed {
    logic            valid;
    reg_addr_t       rd;
    logic            wreg;
    logic            memrd;
    logic            memwr;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] store_data;
  } ex_mem_t;

  typedef struct packed {
    logic            valid;
    reg_addr_t       rd;
    logic [XLEN-1:0] data;
  } wb_t;

  function automatic reg_addr_t reg_convert(input logic [4:0] field);
    return reg_addr_t'(field);
  endfunction

endpackage

// ==== hdl/if_stage.sv ====
`timescale 1ns/1ps

module if_stage
  import cpu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            stall_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] target_i,
  input  logic [ILEN-1:0] instr_i,
  output logic [XLEN-1:0] pc_o,
  output logic [XLEN-1:0] id_pc_o,
  output logic [ILEN-1:0] id_instr_o,
  output logic            id_valid_o
);

  logic [XLEN-1:0] pc_q;

  assign pc_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q       <= RESET_PC;
      id_instr_o <= NOP_INSTR;
      id_valid_o <= 1'b0;
    end else if (stall_i) begin
      // Hold PC and IF/ID
    end else if (redirect_i) begin
      pc_q       <= target_i;
      id_instr_o <= NOP_INSTR;  // Squash the wrong-path fetch
      id_valid_o <= 1'b0;
    end else begin
      pc_q       <= pc_q + XLEN'(4);
      id_instr_o <= instr_i;
      id_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i && !redirect_i) id_pc_o <= pc_q;
  end

  // Targets come from decode, so a bad JAL/JALR offset shows up here
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pc_q[1:0] == 2'b00)
    else $error("if_stage: misaligned pc %h", pc_q);

endmodule

// ==== hdl/id.sv ====
`timescale 1ns/1ps

module id
  import cpu_pkg::*;
(
  input  logic [XLEN-1:0] pc_i,
  input  logic [ILEN-1:0] inst_i,
  input  logic            valid_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  input  fwd_t            ex_fwd_i,
  input  fwd_t            mem_fwd_i,
  output logic            rs1_read_o,
  output logic            rs2_read_o,
  output reg_addr_t       rs1_addr_o,
  output reg_addr_t       rs2_addr_o,
  output id_ex_t          dec_o,
  output logic            branch_taken_o,
  output logic [XLEN-1:0] branch_target_o,
  output logic            stallreq_o
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] rs1_val, rs2_val;
  logic [XLEN-1:0] jalr_sum;
  logic            inst_ok;
  aluop_e          aluop;
  alu_src1_e       src1;
  alu_src2_e       src2;
  logic [XLEN-1:0] imm;
  reg_addr_t       rd;
  logic            wreg, memrd, memwr;
  logic            is_jal, is_jalr, is_branch;
  logic            br_cond;

  // Newest producer wins, x0 never forwarded
  function automatic logic [XLEN-1:0] fwd_select(input logic rd_en, input reg_addr_t addr,
                                                 input logic [XLEN-1:0] rf_data,
                                                 input fwd_t ex, input fwd_t mem);
    if (!rd_en || addr == '0) return '0;
    if (ex.wreg && ex.rd == addr) return ex.data;
    if (mem.wreg && mem.rd == addr) return mem.data;
    return rf_data;
  endfunction

  // Load data only exists at write-back
  function automatic logic load_use(input logic rd_en, input reg_addr_t addr,
                                    input fwd_t ex, input fwd_t mem);
    if (!rd_en || addr == '0) return 1'b0;
    if (ex.wreg && ex.rd == addr) return ex.memrd;
    if (mem.wreg && mem.rd == addr) return mem.memrd;
    return 1'b0;
  endfunction

  function automatic aluop_e arith_op(input logic [2:0] f3, input logic alt,
                                      input logic is_reg);
    case (f3)
      F3_ADD:  return (alt && is_reg) ? ALUOP_SUB : ALUOP_ADD;
      F3_SLL:  return ALUOP_SLL;
      F3_SLT:  return ALUOP_SLT;
      F3_SLTU: return ALUOP_SLTU;
      F3_XOR:  return ALUOP_XOR;
      F3_SR:   return alt ? ALUOP_SRA : ALUOP_SRL;
      F3_OR:   return ALUOP_OR;
      default: return ALUOP_AND;
    endcase
  endfunction

  assign opcode     = opcode_e'(inst_i[6:0]);
  assign funct3     = inst_i[14:12];
  assign link       = pc_i + XLEN'(4);
  assign rs1_addr_o = reg_convert(inst_i[19:15]);
  assign rs2_addr_o = reg_convert(inst_i[24:20]);

  always_comb begin
    inst_ok    = 1'b0;
    aluop      = ALUOP_ADD;
    src1       = SRC1_REG;
    src2       = SRC2_REG;
    imm        = '0;
    rd         = '0;
    wreg       = 1'b0;
    memrd      = 1'b0;
    memwr      = 1'b0;
    rs1_read_o = 1'b0;
    rs2_read_o = 1'b0;
    is_jal     = 1'b0;
    is_jalr    = 1'b0;
    is_branch  = 1'b0;
    if (valid_i) begin
      case (opcode)
        OP_LUI, OP_AUIPC: begin
          inst_ok = 1'b1;
          src1    = (opcode == OP_LUI) ? SRC1_ZERO : SRC1_PC;
          src2    = SRC2_IMM;
          imm     = {inst_i[31:12], 12'b0};
          rd      = reg_convert(inst_i[11:7]);
          wreg    = 1'b1;
        end
        OP_JAL: begin
          inst_ok = 1'b1;
          aluop   = ALUOP_LINK;
          imm     = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
          rd      = reg_convert(inst_i[11:7]);
          wreg    = 1'b1;
          is_jal  = 1'b1;
        end
        OP_JALR: begin
          inst_ok    = 1'b1;
          aluop      = ALUOP_LINK;
          imm        = {{20{inst_i[31]}}, inst_i[31:20]};
          rd         = reg_convert(inst_i[11:7]);
          wreg       = 1'b1;
          rs1_read_o = 1'b1;
          is_jalr    = 1'b1;
        end
        OP_BRANCH: begin
          inst_ok    = 1'b1;
          imm        = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
          rs1_read_o = 1'b1;
          rs2_read_o = 1'b1;
          is_branch  = 1'b1;
        end
        OP_LOAD: begin
          inst_ok    = 1'b1;
          src2       = SRC2_IMM;
          imm        = {{20{inst_i[31]}}, inst_i[31:20]};
          rd         = reg_convert(inst_i[11:7]);
          wreg       = 1'b1;
          memrd      = 1'b1;
          rs1_read_o = 1'b1;
        end
        OP_STORE: begin
          inst_ok    = 1'b1;
          src2       = SRC2_IMM;  // Address, rs2 rides along as store data
          imm        = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
          memwr      = 1'b1;
          rs1_read_o = 1'b1;
          rs2_read_o = 1'b1;
        end
        OP_ARITHI: begin
          inst_ok    = 1'b1;
          aluop      = arith_op(funct3, inst_i[30], 1'b0);
          src2       = SRC2_IMM;
          imm        = {{20{inst_i[31]}}, inst_i[31:20]};
          rd         = reg_convert(inst_i[11:7]);
          wreg       = 1'b1;
          rs1_read_o = 1'b1;
        end
        OP_ARITHR: begin
          inst_ok    = 1'b1;
          aluop      = arith_op(funct3, inst_i[30], 1'b1);
          rd         = reg_convert(inst_i[11:7]);
          wreg       = 1'b1;
          rs1_read_o = 1'b1;
          rs2_read_o = 1'b1;
        end
        OP_FENCE:  inst_ok = 1'b1;  // Nothing to order here
        OP_SYSTEM: ;                // No CSRs, drops to a bubble
        default:   ;
      endcase
    end
  end

  assign rs1_val = fwd_select(rs1_read_o, rs1_addr_o, rs1_data_i, ex_fwd_i, mem_fwd_i);
  assign rs2_val = fwd_select(rs2_read_o, rs2_addr_o, rs2_data_i, ex_fwd_i, mem_fwd_i);

  assign stallreq_o = load_use(rs1_read_o, rs1_addr_o, ex_fwd_i, mem_fwd_i) |
                      load_use(rs2_read_o, rs2_addr_o, ex_fwd_i, mem_fwd_i);

  always_comb begin
    case (branch_f3_e'(funct3))
      BEQ:     br_cond = rs1_val == rs2_val;
      BNE:     br_cond = rs1_val != rs2_val;
      BLT:     br_cond = $signed(rs1_val) < $signed(rs2_val);
      BGE:     br_cond = $signed(rs1_val) >= $signed(rs2_val);
      BLTU:    br_cond = rs1_val < rs2_val;
      BGEU:    br_cond = rs1_val >= rs2_val;
      default: br_cond = 1'b0;
    endcase
  end

  assign jalr_sum        = rs1_val + imm;
  assign branch_taken_o  = is_jal | is_jalr | (is_branch & br_cond);
  assign branch_target_o = is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm;

  assign dec_o = '{
    valid:    inst_ok,
    aluop:    aluop,
    src1:     src1,
    src2:     src2,
    pc:       pc_i,
    imm:      imm,
    link:     link,
    rs1_data: rs1_val,
    rs2_data: rs2_val,
    rd:       rd,
    wreg:     wreg,
    memrd:    memrd,
    memwr:    memwr
  };

  // A stall must come from a live instruction reading a register
  always_comb begin
    a_stall_src: assert #0 (!stallreq_o || (valid_i && (rs1_read_o || rs2_read_o)))
      else $error("id: stall without a register read");
  end

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

module regfile
  import cpu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            rs1_read_i,
  input  logic            rs2_read_i,
  input  reg_addr_t       rs1_addr_i,
  input  reg_addr_t       rs2_addr_i,
  output logic [XLEN-1:0] rs1_data_o,
  output logic [XLEN-1:0] rs2_data_o,
  input  wb_t             wb_i
);

  logic [XLEN-1:0] regs [1:31];  // x0 is not stored

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wb_i.valid && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // Write-through covers the write-back stage
  assign rs1_data_o = (!rs1_read_i || rs1_addr_i == '0) ? '0 :
                      (wb_i.valid && wb_i.rd == rs1_addr_i) ? wb_i.data : regs[rs1_addr_i];
  assign rs2_data_o = (!rs2_read_i || rs2_addr_i == '0) ? '0 :
                      (wb_i.valid && wb_i.rd == rs2_addr_i) ? wb_i.data : regs[rs2_addr_i];

endmodule

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage
  import cpu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    bubble_i,
  input  id_ex_t  dec_i,
  output fwd_t    ex_fwd_o,
  output ex_mem_t ex_mem_o
);

  id_ex_t          id_ex_q;
  logic [XLEN-1:0] op1, op2;
  logic [XLEN-1:0] alu_res;
  logic [4:0]      shamt;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || bubble_i) id_ex_q <= '0;
    else id_ex_q <= dec_i;
  end

  always_comb begin
    case (id_ex_q.src1)
      SRC1_PC:   op1 = id_ex_q.pc;
      SRC1_ZERO: op1 = '0;  // LUI
      default:   op1 = id_ex_q.rs1_data;
    endcase
    op2 = (id_ex_q.src2 == SRC2_IMM) ? id_ex_q.imm : id_ex_q.rs2_data;
  end

  assign shamt = op2[4:0];

  always_comb begin
    case (id_ex_q.aluop)
      ALUOP_ADD:  alu_res = op1 + op2;
      ALUOP_SUB:  alu_res = op1 - op2;
      ALUOP_SLL:  alu_res = op1 << shamt;
      ALUOP_SLT:  alu_res = XLEN'($signed(op1) < $signed(op2));
      ALUOP_SLTU: alu_res = XLEN'(op1 < op2);
      ALUOP_XOR:  alu_res = op1 ^ op2;
      ALUOP_SRL:  alu_res = op1 >> shamt;
      ALUOP_SRA:  alu_res = $signed(op1) >>> shamt;
      ALUOP_OR:   alu_res = op1 | op2;
      ALUOP_AND:  alu_res = op1 & op2;
      ALUOP_LINK: alu_res = id_ex_q.link;  // pc+4 for JAL/JALR
      default:    alu_res = '0;
    endcase
  end

  assign ex_fwd_o = '{
    wreg:  id_ex_q.valid & id_ex_q.wreg,
    rd:    id_ex_q.rd,
    memrd: id_ex_q.memrd,
    data:  alu_res
  };

  assign ex_mem_o = '{
    valid:      id_ex_q.valid,
    rd:         id_ex_q.rd,
    wreg:       id_ex_q.wreg,
    memrd:      id_ex_q.memrd,
    memwr:      id_ex_q.memwr,
    alu_res:    alu_res,
    store_data: id_ex_q.rs2_data
  };

  a_ld_st_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(id_ex_q.memrd && id_ex_q.memwr))
    else $error("ex_stage: load and store set together");

endmodule

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
  import cpu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  ex_mem_t ex_mem_i,
  output fwd_t    mem_fwd_o,
  output wb_t     wb_o
);

  ex_mem_t              ex_mem_q;
  wb_t                  wb_q;
  logic [XLEN-1:0]      dmem [DMEM_WORDS];
  logic [DMEM_AW-1:0]   dmem_idx;
  logic [XLEN-1:0]      load_data;

  assign dmem_idx  = ex_mem_q.alu_res[DMEM_AW+1:2];  // Word address
  assign load_data = dmem[dmem_idx];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) ex_mem_q <= '0;
    else ex_mem_q <= ex_mem_i;
  end

  always_ff @(posedge clk_i) begin
    if (ex_mem_q.valid && ex_mem_q.memwr) dmem[dmem_idx] <= ex_mem_q.store_data;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_q <= '0;
    end else begin
      wb_q.valid <= ex_mem_q.valid && ex_mem_q.wreg && ex_mem_q.rd != '0;
      wb_q.rd    <= ex_mem_q.rd;
      wb_q.data  <= ex_mem_q.memrd ? load_data : ex_mem_q.alu_res;
    end
  end

  assign mem_fwd_o = '{
    wreg:  ex_mem_q.valid & ex_mem_q.wreg,
    rd:    ex_mem_q.rd,
    memrd: ex_mem_q.memrd,
    data:  ex_mem_q.alu_res
  };

  assign wb_o = wb_q;

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  output logic [XLEN-1:0] imem_addr_o,
  input  logic [ILEN-1:0] imem_data_i,
  output logic            wb_valid_o,
  output reg_addr_t       wb_rd_o,
  output logic [XLEN-1:0] wb_data_o
);

  logic            stallreq;
  logic            branch_taken;
  logic            redirect;
  logic [XLEN-1:0] branch_target;
  logic [XLEN-1:0] id_pc;
  logic [ILEN-1:0] id_instr;
  logic            id_valid;
  logic            rs1_read, rs2_read;
  reg_addr_t       rs1_addr, rs2_addr;
  logic [XLEN-1:0] rs1_data, rs2_data;
  id_ex_t          dec;
  fwd_t            ex_fwd, mem_fwd;
  ex_mem_t         ex_mem;
  wb_t             wb;

  assign redirect = branch_taken & ~stallreq;  // Outcome not final while stalled

  if_stage if_stage_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .stall_i    (stallreq),
    .redirect_i (redirect),
    .target_i   (branch_target),
    .instr_i    (imem_data_i),
    .pc_o       (imem_addr_o),
    .id_pc_o    (id_pc),
    .id_instr_o (id_instr),
    .id_valid_o (id_valid)
  );

  id id_i (
    .pc_i            (id_pc),
    .inst_i          (id_instr),
    .valid_i         (id_valid),
    .rs1_data_i      (rs1_data),
    .rs2_data_i      (rs2_data),
    .ex_fwd_i        (ex_fwd),
    .mem_fwd_i       (mem_fwd),
    .rs1_read_o      (rs1_read),
    .rs2_read_o      (rs2_read),
    .rs1_addr_o      (rs1_addr),
    .rs2_addr_o      (rs2_addr),
    .dec_o           (dec),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .stallreq_o      (stallreq)
  );

  regfile regfile_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_read_i (rs1_read),
    .rs2_read_i (rs2_read),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb)
  );

  ex_stage ex_stage_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .bubble_i (stallreq),
    .dec_i    (dec),
    .ex_fwd_o (ex_fwd),
    .ex_mem_o (ex_mem)
  );

  mem_stage mem_stage_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ex_mem_i  (ex_mem),
    .mem_fwd_o (mem_fwd),
    .wb_o      (wb)
  );

  assign wb_valid_o = wb.valid;
  assign wb_rd_o    = wb.rd;
  assign wb_data_o  = wb.data;

endmodule

// ==== test/rv_model.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

  // Architectural state of the reference ISA model
  logic [XLEN-1:0] ref_regs [32];
  logic [XLEN-1:0] ref_mem [256];  // Word index is address bits [9:2]
  logic [XLEN-1:0] ref_pc;
  int              prog_len;

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // SW only
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    case (f3)
      3'b000: begin
        if (alt) return a - b;
        return a + b;
      end
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Runs the instruction at ref_pc, returns 1 when a nonzero rd is written
  function automatic logic execute_instr(output logic [4:0] rd, output logic [XLEN-1:0] val);
    logic [31:0]     ins;
    logic [XLEN-1:0] a, b, imm_i, imm_s, next_pc;
    logic            wr, take;
    ins     = prog[ref_pc[9:2]];
    a       = ref_regs[ins[19:15]];
    b       = ref_regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    rd      = ins[11:7];
    val     = '0;
    wr      = 1'b0;
    take    = 1'b0;
    next_pc = ref_pc + 4;
    case (ins[6:0])
      7'b0110111: begin  // LUI
        wr  = 1'b1;
        val = {ins[31:12], 12'b0};
      end
      7'b0010111: begin  // AUIPC
        wr  = 1'b1;
        val = ref_pc + {ins[31:12], 12'b0};
      end
      7'b1101111: begin  // JAL
        wr      = 1'b1;
        val     = ref_pc + 4;
        next_pc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b1100111: begin  // JALR
        wr      = 1'b1;
        val     = ref_pc + 4;
        next_pc = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        case (ins[14:12])
          3'b000:  take = a == b;
          3'b001:  take = a != b;
          3'b100:  take = $signed(a) < $signed(b);
          3'b101:  take = $signed(a) >= $signed(b);
          3'b110:  take = a < b;
          3'b111:  take = a >= b;
          default: take = 1'b0;
        endcase
        if (take) next_pc = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      7'b0000011: begin  // Any load is a word load
        wr  = 1'b1;
        val = ref_mem[(a + imm_i) >> 2 & 32'hff];
      end
      7'b0100011: ref_mem[(a + imm_s) >> 2 & 32'hff] = b;
      7'b0010011: begin
        wr  = 1'b1;
        val = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
      end
      7'b0110011: begin
        wr  = 1'b1;
        val = alu_ref(ins[14:12], ins[30], a, b);
      end
      default: ;  // FENCE, SYSTEM and unknown opcodes change nothing
    endcase
    if (wr && rd != 5'd0) ref_regs[rd] = val;
    ref_pc = next_pc;
    return wr && rd != 5'd0;
  endfunction

`endif

// ==== test/cpu_top_tb.sv ====
`timescale 1ns/1ps

module cpu_top_tb
  import cpu_pkg::*;
();

  logic            clk = 1'b0;
  logic            rst_n;
  logic [XLEN-1:0] imem_addr;
  logic [ILEN-1:0] imem_data;
  logic            wb_valid;
  reg_addr_t       wb_rd;
  logic [XLEN-1:0] wb_data;

  logic [ILEN-1:0] prog [256];
  wb_t             expect_q [$];
  int              errors;
  int              retired;
  int              expected_total;
  integer          seed = 32'he29d_13c0;

  `include "rv_model.svh"

  cpu_top cpu_top_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .wb_valid_o  (wb_valid),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  assign imem_data = prog[imem_addr[9:2]];

  always #10 clk = ~clk;

  task automatic wrong_path();
    emit(i_type(OP_ARITHI, 5'd31, F3_ADD, 5'd0, 12'h7ff));
  endtask

  // Taken case skips the marker, not-taken case retires it
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] a, input logic [4:0] b,
                             input logic [11:0] mark);
    emit(b_type(f3, a, b, 13'd8));
    emit(i_type(OP_ARITHI, 5'd31, F3_ADD, 5'd0, mark));
  endtask

  task automatic add_random_arith(input int count);
    logic [31:0] rnd;
    logic [31:0] rnd_imm;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    for (int n = 0; n < count; n++) begin
      rnd     = $random(seed);
      rnd_imm = $random(seed);
      f3      = rnd[14:12];
      alt     = rnd[15] && (f3 == F3_ADD || f3 == F3_SR);
      if (rnd[16]) begin
        emit(r_type(alt ? 7'h20 : 7'h00, {1'b0, rnd[11:8]}, {1'b0, rnd[7:4]}, f3,
                    {1'b0, rnd[3:0]}));
      end else begin
        case (f3)
          F3_SLL:  imm = {7'h00, rnd_imm[4:0]};
          F3_SR:   imm = {alt ? 7'h20 : 7'h00, rnd_imm[4:0]};
          default: imm = rnd_imm[11:0];
        endcase
        emit(i_type(OP_ARITHI, {1'b0, rnd[3:0]}, f3, {1'b0, rnd[7:4]}, imm));
      end
    end
  endtask

  task automatic build_program();
    // Unused words are no-ops whose immediate is their own index
    for (int i = 0; i < 256; i++) prog[i] = i_type(OP_ARITHI, 5'd0, F3_ADD, 5'd0, 12'(i));
    prog_len = 0;
    emit(u_type(OP_LUI, 5'd1, 20'h12345));
    emit(i_type(OP_ARITHI, 5'd1, F3_ADD, 5'd1, 12'h678));
    emit(u_type(OP_AUIPC, 5'd2, 20'h00001));
    emit(i_type(OP_ARITHI, 5'd3, F3_ADD, 5'd0, 12'hffb));
    add_random_arith(40);
    emit(r_type(7'h00, 5'd3, 5'd1, F3_ADD, 5'd4));
    emit(r_type(7'h20, 5'd1, 5'd4, F3_ADD, 5'd5));   // Distance 1
    emit(r_type(7'h00, 5'd5, 5'd4, F3_XOR, 5'd6));   // Distances 1 and 2
    emit(r_type(7'h20, 5'd3, 5'd6, F3_SR, 5'd7));
    emit(r_type(7'h00, 5'd6, 5'd7, F3_SLT, 5'd4));
    emit(r_type(7'h00, 5'd3, 5'd7, F3_SLTU, 5'd5));
    // Stores, loads and load-use
    emit(i_type(OP_ARITHI, 5'd8, F3_ADD, 5'd0, 12'h040));
    emit(s_type(5'd1, 5'd8, 12'd0));
    emit(s_type(5'd2, 5'd8, 12'd4));
    emit(i_type(OP_LOAD, 5'd9, 3'b010, 5'd8, 12'd0));
    emit(r_type(7'h00, 5'd9, 5'd9, F3_ADD, 5'd10));  // Load still in EX
    emit(i_type(OP_LOAD, 5'd11, 3'b010, 5'd8, 12'd4));
    emit(r_type(7'h00, 5'd3, 5'd0, F3_ADD, 5'd12));
    emit(r_type(7'h00, 5'd12, 5'd11, F3_ADD, 5'd13)); // Load in MEM
    emit(s_type(5'd10, 5'd8, 12'd8));
    emit(i_type(OP_LOAD, 5'd14, 3'b010, 5'd8, 12'd8));
    emit(s_type(5'd14, 5'd8, 12'd12));
    emit(i_type(OP_LOAD, 5'd15, 3'b010, 5'd8, 12'd12));
    emit(i_type(OP_ARITHI, 5'd20, F3_ADD, 5'd0, 12'hffd));
    emit(i_type(OP_ARITHI, 5'd21, F3_ADD, 5'd0, 12'd5));
    emit(i_type(OP_ARITHI, 5'd22, F3_ADD, 5'd0, 12'd5));
    branch_case(BEQ, 5'd21, 5'd22, 12'd1);
    branch_case(BEQ, 5'd20, 5'd21, 12'd2);
    branch_case(BNE, 5'd20, 5'd21, 12'd3);
    branch_case(BNE, 5'd21, 5'd22, 12'd4);
    branch_case(BLT, 5'd20, 5'd21, 12'd5);
    branch_case(BLT, 5'd21, 5'd20, 12'd6);
    branch_case(BGE, 5'd21, 5'd20, 12'd7);
    branch_case(BGE, 5'd20, 5'd21, 12'd8);
    branch_case(BLTU, 5'd21, 5'd20, 12'd9);
    branch_case(BLTU, 5'd20, 5'd21, 12'd10);
    branch_case(BGEU, 5'd20, 5'd21, 12'd11);
    branch_case(BGEU, 5'd21, 5'd20, 12'd12);
    emit(i_type(OP_LOAD, 5'd23, 3'b010, 5'd8, 12'd0));
    branch_case(BEQ, 5'd23, 5'd1, 12'd13);           // Operand straight from a load
    emit(i_type(OP_ARITHI, 5'd24, F3_ADD, 5'd0, 12'd3));
    emit(i_type(OP_ARITHI, 5'd24, F3_ADD, 5'd24, 12'hfff));
    emit(i_type(OP_ARITHI, 5'd25, F3_ADD, 5'd25, 12'd1));
    emit(b_type(BNE, 5'd24, 5'd0, 13'h1ff8));        // Back two words
    // Jumps
    emit(j_type(5'd26, 21'd8));
    wrong_path();
    emit(u_type(OP_AUIPC, 5'd27, 20'h0));
    emit(i_type(OP_JALR, 5'd28, 3'b000, 5'd27, 12'd12));
    wrong_path();
    emit(u_type(OP_AUIPC, 5'd27, 20'h0));
    emit(i_type(OP_ARITHI, 5'd27, F3_ADD, 5'd27, 12'd24));
    emit(s_type(5'd27, 5'd8, 12'd16));
    emit(i_type(OP_LOAD, 5'd29, 3'b010, 5'd8, 12'd16));
    emit(i_type(OP_JALR, 5'd30, 3'b000, 5'd29, 12'd0));
    wrong_path();
    // Writes to x0 and reads of it
    emit(i_type(OP_ARITHI, 5'd0, F3_ADD, 5'd1, 12'd1));
    emit(r_type(7'h00, 5'd1, 5'd0, F3_ADD, 5'd16));
    emit(u_type(OP_LUI, 5'd0, 20'hfffff));
    emit(j_type(5'd0, 21'd8));
    wrong_path();
    emit(r_type(7'h00, 5'd0, 5'd0, F3_ADD, 5'd17));
    emit(j_type(5'd0, 21'd0));                        // Self loop ends the program
  endtask

  task automatic run_model();
    wb_t ret;
    int  steps;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    ref_pc = RESET_PC;
    steps  = 0;
    while (prog[ref_pc[9:2]] != 32'h0000_006f && steps < 2000) begin
      if (execute_instr(ret.rd, ret.data)) begin
        ret.valid = 1'b1;
        expect_q.push_back(ret);
      end
      steps++;
    end
  endtask

  always @(negedge clk) begin : compare
    wb_t exp_ret;
    if (!rst_n) begin
      assert (wb_valid !== 1'b1) else begin
        errors++;
        $display("Write-back seen during reset at %0t ns", $time);
      end
    end else if (wb_valid === 1'b1) begin
      assert (expect_q.size() > 0) else begin
        errors++;
        $display("Extra retirement at %0t ns, x%0d written with nothing expected", $time,
                 wb_rd);
      end
      if (expect_q.size() > 0) begin
        exp_ret = expect_q.pop_front();
        retired++;
        assert (wb_rd == exp_ret.rd) else begin
          errors++;
          $display("FAIL %0t ns wb_rd_o got %0d expected %0d", $time, wb_rd, exp_ret.rd);
        end
        assert (wb_data == exp_ret.data) else begin
          errors++;
          $display("FAIL %0t ns wb_data_o got %h expected %h", $time, wb_data, exp_ret.data);
        end
      end
    end
  end

  initial begin
    int idle;
    int last;
    errors  = 0;
    retired = 0;
    rst_n   = 1'b0;
    build_program();
    run_model();
    expected_total = expect_q.size();
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    idle = 0;
    while (retired < expected_total && idle < 200) begin
      last = retired;
      @(posedge clk);
      idle = (retired != last) ? 0 : idle + 1;
    end
    if (retired < expected_total) begin
      errors++;
      $display("Timeout: retirements stopped after %0d of %0d", retired, expected_total);
    end
    repeat (20) @(posedge clk);  // Anything retiring now is extra
    #1;
    // Self loop fetches its own word and the flushed one after it
    assert (imem_addr == ref_pc || imem_addr == ref_pc + 4) else begin
      errors++;
      $display("FAIL %0t ns imem_addr_o got %h expected %h", $time, imem_addr, ref_pc);
    end
    $display("Errors: %0d, retired %0d of %0d", errors, retired, expected_total);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== cpu_top.f ====
+incdir+test
hdl/cpu_pkg.sv
hdl/if_stage.sv
hdl/id.sv
hdl/regfile.sv
hdl/ex_stage.sv
hdl/mem_stage.sv
hdl/cpu_top.sv
test/cpu_top_tb.sv
